//--- logic/isaPkg.sv
// Opcode encodings shared by the issue port, both execution units and the testbench model
// SLT, BLT and BGE compare the operands as signed values

package isaPkg;

  // ALU operations, codes 6 and 7 are unused
  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SLT = 3'd5  // Signed set-less-than
  } aluOp_e;

  // Branch compare conditions
  typedef enum logic [1:0] {
    BEQ = 2'd0,
    BNE = 2'd1,
    BLT = 2'd2, // Signed
    BGE = 2'd3  // Signed
  } branchCond_e;

  // Which unit an issued operation goes to
  typedef enum logic {
    OP_ALU    = 1'b0,
    OP_BRANCH = 1'b1
  } opKind_e;

endpackage

//--- logic/ctrlPkg.sv
// Control state encodings for the branch sequencer and the reorder buffer entries

package ctrlPkg;

  // Branch unit sequencing
  typedef enum logic [1:0] {
    IDLE    = 2'd0, // Free for a new branch
    EXECUTE = 2'd1, // Latency timer running
    REQUEST = 2'd2  // Waiting for the CDB
  } branchState_e;

  // Reorder buffer entry life cycle
  typedef enum logic [1:0] {
    FREE    = 2'd0,
    WAITING = 2'd1, // Allocated, result not yet broadcast
    DONE    = 2'd2  // Result captured from the CDB
  } entryState_e;

endpackage

//--- logic/aluUnit.sv
// Single-cycle ALU holding one result until the CDB arbiter takes it
// start is only honoured while the unit is not busy

`timescale 1ns/1ps

module aluUnit #(
  parameter int WIDTH    = 32,
  parameter int TAG_BITS = 3
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                flush,
  input  logic                start,
  input  isaPkg::aluOp_e      op,
  input  logic [WIDTH-1:0]    operandA,
  input  logic [WIDTH-1:0]    operandB,
  input  logic [TAG_BITS-1:0] tagIn,
  input  logic                available,
  output logic                request,
  output logic                busy,
  output logic [WIDTH-1:0]    result,
  output logic [TAG_BITS-1:0] tag
);

  logic [WIDTH-1:0] aluOut;

  always_comb begin
    case (op)
      isaPkg::ADD: aluOut = operandA + operandB;
      isaPkg::SUB: aluOut = operandA - operandB;
      isaPkg::AND: aluOut = operandA & operandB;
      isaPkg::OR:  aluOut = operandA | operandB;
      isaPkg::XOR: aluOut = operandA ^ operandB;
      isaPkg::SLT: aluOut = {{(WIDTH-1){1'b0}}, $signed(operandA) < $signed(operandB)};
      default:     aluOut = '0; // Unused codes
    endcase
  end

  // Request held from the issue edge until the grant edge
  always_ff @(posedge clk) begin
    if (rst) begin
      request <= 1'b0;
    end else if (flush) begin
      request <= 1'b0; // Work is squashed
    end else if (start && !request) begin
      request <= 1'b1;
    end else if (request && available) begin
      request <= 1'b0; // Granted, result now on the CDB
    end
  end

  always_ff @(posedge clk) begin
    if (start && !request) begin
      result <= aluOut;
      tag    <= tagIn;
    end
  end

  assign busy = request; // Busy exactly while the result waits for the bus

endmodule

//--- logic/latencyTimer.sv
// Down counter for the branch execute latency, BRANCH_LATENCY must be at least 1
// expired marks the last execute cycle so the sequencer leaves EXECUTE on that edge

`timescale 1ns/1ps

module latencyTimer #(
  parameter int BRANCH_LATENCY = 3
) (
  input  logic clk,
  input  logic rst,
  input  logic load,
  input  logic cancel,
  output logic expired
);

  localparam int CNT_BITS = $clog2(BRANCH_LATENCY + 1);

  logic [CNT_BITS-1:0] count; // Zero when idle

  always_ff @(posedge clk) begin
    if (rst || cancel) begin
      count <= '0; // Cancel stops without an expired pulse
    end else if (load) begin
      count <= CNT_BITS'(BRANCH_LATENCY);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign expired = (count == CNT_BITS'(1)); // Reaches zero on the next edge

endmodule

//--- logic/branchSequencer.sv
// FSM stepping the branch unit through IDLE, EXECUTE and REQUEST
// A new branch is only taken in IDLE, flush wins over every other transition

`timescale 1ns/1ps

module branchSequencer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush,
  input  logic                  start,
  input  logic                  expired,
  input  logic                  available,
  output ctrlPkg::branchState_e state,
  output logic                  loadTimer,
  output logic                  request,
  output logic                  busy
);

  ctrlPkg::branchState_e nextState;

  always_comb begin
    nextState = state;
    case (state)
      ctrlPkg::IDLE:    if (start) nextState = ctrlPkg::EXECUTE;
      ctrlPkg::EXECUTE: if (expired) nextState = ctrlPkg::REQUEST;
      ctrlPkg::REQUEST: if (available) nextState = ctrlPkg::IDLE; // Grant seen
      default:          nextState = ctrlPkg::IDLE;
    endcase
    if (flush) nextState = ctrlPkg::IDLE;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ctrlPkg::IDLE;
    end else begin
      state <= nextState;
    end
  end

  assign loadTimer = (state == ctrlPkg::IDLE) && start && !flush; // Same edge as entering EXECUTE
  assign request   = (state == ctrlPkg::REQUEST);
  assign busy      = (state != ctrlPkg::IDLE);

endmodule

//--- logic/branchUnit.sv
// Branch compare unit with a fixed execute latency
// Broadcast result is the taken flag, the target is carried through unchanged

`timescale 1ns/1ps

module branchUnit #(
  parameter int WIDTH          = 32,
  parameter int TAG_BITS       = 3,
  parameter int BRANCH_LATENCY = 3
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                flush,
  input  logic                start,
  input  isaPkg::branchCond_e cond,
  input  logic [WIDTH-1:0]    operandA,
  input  logic [WIDTH-1:0]    operandB,
  input  logic [WIDTH-1:0]    targetIn,
  input  logic [TAG_BITS-1:0] tagIn,
  input  logic                available,
  output logic                request,
  output logic                busy,
  output logic                taken,
  output logic [WIDTH-1:0]    target,
  output logic [TAG_BITS-1:0] tag
);

  ctrlPkg::branchState_e seqState;
  logic                  loadTimer;
  logic                  expired;
  isaPkg::branchCond_e   condReg;
  logic [WIDTH-1:0]      aReg, bReg;

  branchSequencer seq0 (
    .clk(clk), .rst(rst), .flush(flush), .start(start), .expired(expired),
    .available(available), .state(seqState), .loadTimer(loadTimer),
    .request(request), .busy(busy)
  );

  latencyTimer #(.BRANCH_LATENCY(BRANCH_LATENCY)) timer0 (
    .clk(clk), .rst(rst), .load(loadTimer), .cancel(flush), .expired(expired)
  );

  // Capture only when the sequencer accepts the branch
  always_ff @(posedge clk) begin
    if (start && seqState == ctrlPkg::IDLE) begin
      condReg <= cond;
      aReg    <= operandA;
      bReg    <= operandB;
      target  <= targetIn;
      tag     <= tagIn;
    end
  end

  // Settles from the held operands during the execute cycles
  always_comb begin
    case (condReg)
      isaPkg::BEQ: taken = (aReg == bReg);
      isaPkg::BNE: taken = (aReg != bReg);
      isaPkg::BLT: taken = ($signed(aReg) < $signed(bReg));
      isaPkg::BGE: taken = ($signed(aReg) >= $signed(bReg));
      default:     taken = 1'b0;
    endcase
  end

endmodule

//--- logic/cdbArbiter.sv
// Round-robin arbiter for the common data bus between the ALU and branch units
// Broadcast is registered, available outputs are combinational from the requests

`timescale 1ns/1ps

module cdbArbiter #(
  parameter int WIDTH    = 32,
  parameter int TAG_BITS = 3
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                clear,
  input  logic                aluRequest,
  input  logic                branchRequest,
  input  logic                branchTaken,
  input  logic [WIDTH-1:0]    aluResult,
  input  logic [WIDTH-1:0]    branchTarget,
  input  logic [TAG_BITS-1:0] aluTag,
  input  logic [TAG_BITS-1:0] branchTag,
  output logic                aluAvailable,
  output logic                branchAvailable,
  output logic                cdbValid,
  output logic                cdbIsBranch,
  output logic                cdbTaken,
  output logic [WIDTH-1:0]    cdbResult,
  output logic [WIDTH-1:0]    cdbTarget,
  output logic [TAG_BITS-1:0] cdbTag
);

  logic pointer;  // 0 favours the ALU, 1 favours the branch unit
  logic grantAlu;
  logic grantBranch;
  logic anyGrant;

  always_comb begin
    grantAlu    = 1'b0;
    grantBranch = 1'b0;
    if (pointer) begin
      grantBranch = branchRequest;
      grantAlu    = aluRequest && !branchRequest;
    end else begin
      grantAlu    = aluRequest;
      grantBranch = branchRequest && !aluRequest;
    end
  end

  assign anyGrant = grantAlu || grantBranch;

  // Free when granted this cycle or not waiting at all
  assign aluAvailable    = grantAlu || !aluRequest;
  assign branchAvailable = grantBranch || !branchRequest;

  always_ff @(posedge clk) begin
    if (rst) begin
      pointer  <= 1'b0;
      cdbValid <= 1'b0;
    end else if (clear) begin
      cdbValid <= 1'b0; // Squashed broadcast, pointer left alone
    end else begin
      cdbValid <= anyGrant; // One-cycle strobe per grant
      if (anyGrant) pointer <= grantAlu; // Loser gets priority next time
    end
  end

  // Broadcast payload, meaningful only with cdbValid
  always_ff @(posedge clk) begin
    if (anyGrant) begin
      cdbIsBranch <= grantBranch;
      cdbTag      <= grantBranch ? branchTag : aluTag;
      cdbResult   <= grantBranch ? {{(WIDTH-1){1'b0}}, branchTaken} : aluResult;
      cdbTaken    <= grantBranch && branchTaken;
      cdbTarget   <= branchTarget;
    end
  end

endmodule

//--- logic/reorderBuffer.sv
// Circular reorder buffer of 2**TAG_BITS entries, allocation tag equals the entry index
// Commit outputs are combinational from the head, flush restarts tags after the branch

`timescale 1ns/1ps

module reorderBuffer #(
  parameter int WIDTH    = 32,
  parameter int TAG_BITS = 3
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                allocate,
  input  logic                allocIsBranch,
  input  logic [WIDTH-1:0]    allocTarget,
  input  logic                cdbValid,
  input  logic                cdbTaken,
  input  logic [TAG_BITS-1:0] cdbTag,
  input  logic [WIDTH-1:0]    cdbResult,
  output logic                full,
  output logic                flush,
  output logic                commitValid,
  output logic                commitIsBranch,
  output logic                commitTaken,
  output logic [TAG_BITS-1:0] allocTag,
  output logic [TAG_BITS-1:0] commitTag,
  output logic [WIDTH-1:0]    commitResult,
  output logic [WIDTH-1:0]    commitTarget
);

  localparam int DEPTH = 1 << TAG_BITS;

  logic [TAG_BITS-1:0]  head, tail;
  logic [TAG_BITS:0]    count;
  ctrlPkg::entryState_e state [DEPTH];
  logic [WIDTH-1:0]     result [DEPTH];
  logic [WIDTH-1:0]     target [DEPTH];
  logic                 taken [DEPTH];
  logic                 isBranch [DEPTH];

  assign full     = (count == (TAG_BITS+1)'(DEPTH));
  assign allocTag = tail;

  assign commitValid    = (state[head] == ctrlPkg::DONE); // Head finished
  assign commitTag      = head;
  assign commitResult   = result[head];
  assign commitTarget   = target[head];
  assign commitIsBranch = isBranch[head];
  assign commitTaken    = taken[head];
  assign flush          = commitValid && isBranch[head] && taken[head]; // Taken counts as mispredict

  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < DEPTH; i++) state[i] <= ctrlPkg::FREE;
    end else if (flush) begin
      // Drop everything younger than the committing branch
      head  <= head + 1'b1;
      tail  <= head + 1'b1;
      count <= '0;
      for (int i = 0; i < DEPTH; i++) state[i] <= ctrlPkg::FREE;
    end else begin
      if (allocate) begin
        state[tail] <= ctrlPkg::WAITING;
        tail        <= tail + 1'b1;
      end
      if (cdbValid && state[cdbTag] == ctrlPkg::WAITING) state[cdbTag] <= ctrlPkg::DONE;
      if (commitValid) begin
        state[head] <= ctrlPkg::FREE;
        head        <= head + 1'b1;
      end
      count <= count + (TAG_BITS+1)'(allocate) - (TAG_BITS+1)'(commitValid);
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (allocate) begin
      isBranch[tail] <= allocIsBranch;
      target[tail]   <= allocTarget;
    end
    if (cdbValid) begin
      result[cdbTag] <= cdbResult;
      taken[cdbTag]  <= cdbTaken;
    end
  end

endmodule

//--- logic/writebackCore.sv
// Writeback slice top: issue port, ALU and branch units, CDB arbiter and reorder buffer
// An operation is accepted when issueValid and issueReady are both high

`timescale 1ns/1ps

module writebackCore #(
  parameter int WIDTH          = 32,
  parameter int TAG_BITS       = 3,
  parameter int BRANCH_LATENCY = 3
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                issueValid,
  input  isaPkg::opKind_e     issueKind,
  input  isaPkg::aluOp_e      aluOp,
  input  isaPkg::branchCond_e branchCond,
  input  logic [WIDTH-1:0]    operandA,
  input  logic [WIDTH-1:0]    operandB,
  input  logic [WIDTH-1:0]    issueTarget,
  output logic                issueReady,
  output logic                flush,
  output logic                commitValid,
  output logic                commitIsBranch,
  output logic                commitTaken,
  output logic [TAG_BITS-1:0] commitTag,
  output logic [WIDTH-1:0]    commitResult,
  output logic [WIDTH-1:0]    commitTarget
);

  logic                accept, isBranchOp, robFull;
  logic                aluRequest, aluBusy, aluAvailable;
  logic                branchRequest, branchBusy, branchAvailable, branchTaken;
  logic [WIDTH-1:0]    aluResult, branchTarget, cdbResult;
  logic [TAG_BITS-1:0] aluTag, branchTag, allocTag, cdbTag;
  logic                cdbValid, cdbTaken;

  assign isBranchOp = (issueKind == isaPkg::OP_BRANCH);
  assign issueReady = !robFull && !flush && (isBranchOp ? !branchBusy : !aluBusy);
  assign accept     = issueValid && issueReady;

  // Both units see the tail tag, only the starting one latches it
  aluUnit #(.WIDTH(WIDTH), .TAG_BITS(TAG_BITS)) alu0 (
    .clk(clk), .rst(rst), .flush(flush), .start(accept && !isBranchOp), .op(aluOp),
    .operandA(operandA), .operandB(operandB), .tagIn(allocTag), .available(aluAvailable),
    .request(aluRequest), .busy(aluBusy), .result(aluResult), .tag(aluTag)
  );

  branchUnit #(.WIDTH(WIDTH), .TAG_BITS(TAG_BITS), .BRANCH_LATENCY(BRANCH_LATENCY)) branch0 (
    .clk(clk), .rst(rst), .flush(flush), .start(accept && isBranchOp), .cond(branchCond),
    .operandA(operandA), .operandB(operandB), .targetIn(issueTarget), .tagIn(allocTag),
    .available(branchAvailable), .request(branchRequest), .busy(branchBusy),
    .taken(branchTaken), .target(branchTarget), .tag(branchTag)
  );

  // Branch target reaches commit through the reorder buffer, so cdbTarget stays open here
  cdbArbiter #(.WIDTH(WIDTH), .TAG_BITS(TAG_BITS)) arb0 (
    .clk(clk), .rst(rst), .clear(flush), .aluRequest(aluRequest),
    .branchRequest(branchRequest), .branchTaken(branchTaken), .aluResult(aluResult),
    .branchTarget(branchTarget), .aluTag(aluTag), .branchTag(branchTag),
    .aluAvailable(aluAvailable), .branchAvailable(branchAvailable), .cdbValid(cdbValid),
    .cdbIsBranch(), .cdbTaken(cdbTaken), .cdbResult(cdbResult), .cdbTarget(), .cdbTag(cdbTag)
  );

  reorderBuffer #(.WIDTH(WIDTH), .TAG_BITS(TAG_BITS)) rob0 (
    .clk(clk), .rst(rst), .allocate(accept), .allocIsBranch(isBranchOp),
    .allocTarget(issueTarget), .cdbValid(cdbValid), .cdbTaken(cdbTaken), .cdbTag(cdbTag),
    .cdbResult(cdbResult), .full(robFull), .flush(flush), .commitValid(commitValid),
    .commitIsBranch(commitIsBranch), .commitTaken(commitTaken), .allocTag(allocTag),
    .commitTag(commitTag), .commitResult(commitResult), .commitTarget(commitTarget)
  );

endmodule

//--- tb/tbClock.sv
// Free-running clock and synchronous reset for the testbench
// rst drops 1 ns after the last reset edge so no edge sees it change

`timescale 1ns/1ps

module tbClock #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0; // Clear of the edge
  end

endmodule

//--- tb/tbWritebackCore.sv
// Random issue stream from seed 38028 against an in-order model of the reorder buffer
// Outputs are sampled at the falling edge, where they predict the next rising edge

`timescale 1ns/1ps

module tbWritebackCore;

  localparam int WIDTH          = 32;
  localparam int TAG_BITS       = 3;
  localparam int BRANCH_LATENCY = 3;
  localparam int DEPTH          = 1 << TAG_BITS;
  localparam int NUM_OPS        = 2000;
  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 16;
  localparam int TIMEOUT_NS     = (NUM_OPS * 20 + RESET_CYCLES) * CLK_PERIOD;
  // Issue, broadcast, mark done, plus one lost arbitration
  localparam int ALU_BOUND      = 3 + 1;
  localparam int BRANCH_BOUND   = BRANCH_LATENCY + 3 + 1;

  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    logic                isBranch;
    logic                taken;
    logic [WIDTH-1:0]    result;
    logic [WIDTH-1:0]    target;
    int                  acceptCycle;
    logic                startedEmpty; // Nothing older outstanding at issue
  } expectEntry_t;

  logic                clk, rst;
  logic                issueValid;
  isaPkg::opKind_e     issueKind;
  isaPkg::aluOp_e      aluOp;
  isaPkg::branchCond_e branchCond;
  logic [WIDTH-1:0]    operandA, operandB, issueTarget;
  logic                issueReady, flush, commitValid, commitIsBranch, commitTaken;
  logic [TAG_BITS-1:0] commitTag;
  logic [WIDTH-1:0]    commitResult, commitTarget;

  expectEntry_t        pending [$]; // Uncommitted operations with the oldest first
  integer              seed;
  int                  errorCount, commitCount, flushCount, acceptCount, cycleCount;
  logic [TAG_BITS-1:0] nextTag, lastCommitTag;
  logic                haveLastCommit;
  logic                holding;    // Drawn operation still waiting for issueReady

  tbClock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock0 (.clk(clk), .rst(rst));

  writebackCore dut0 (
    .clk(clk), .rst(rst), .issueValid(issueValid), .issueKind(issueKind), .aluOp(aluOp),
    .branchCond(branchCond), .operandA(operandA), .operandB(operandB),
    .issueTarget(issueTarget), .issueReady(issueReady), .flush(flush),
    .commitValid(commitValid), .commitIsBranch(commitIsBranch), .commitTaken(commitTaken),
    .commitTag(commitTag), .commitResult(commitResult), .commitTarget(commitTarget)
  );

  // Two's complement order from the sign bits first
  function automatic logic signedLess(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
    if (a[WIDTH-1] != b[WIDTH-1]) return a[WIDTH-1];
    return a < b;
  endfunction

  function automatic logic [WIDTH-1:0] expectAlu(input isaPkg::aluOp_e op,
                                                 input logic [WIDTH-1:0] a,
                                                 input logic [WIDTH-1:0] b);
    case (op)
      isaPkg::ADD: return a + b;
      isaPkg::SUB: return a - b;
      isaPkg::AND: return a & b;
      isaPkg::OR:  return a | b;
      isaPkg::XOR: return a ^ b;
      isaPkg::SLT: return {{(WIDTH-1){1'b0}}, signedLess(a, b)};
      default:     return '0;
    endcase
  endfunction

  function automatic logic expectTaken(input isaPkg::branchCond_e cond,
                                       input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
    case (cond)
      isaPkg::BEQ: return a == b;
      isaPkg::BNE: return a != b;
      isaPkg::BLT: return signedLess(a, b);
      default:     return !signedLess(a, b); // BGE
    endcase
  endfunction

  task automatic reportMismatch(input string msg);
    errorCount++;
    $display("** Error: %0d ns: %s", $time, msg);
  endtask

  // New operation on the issue port with branches mostly not taken
  task automatic drawOperation();
    logic [WIDTH-1:0] a, b, swap;
    int unsigned      pick;
    logic             biasNotTaken;
    a           = $random(seed);
    b           = $random(seed);
    issueTarget = $random(seed);
    issueValid  = ($unsigned($random(seed)) % 4) != 0;
    issueKind   = (($unsigned($random(seed)) % 8) < 3) ? isaPkg::OP_BRANCH : isaPkg::OP_ALU;
    pick        = $unsigned($random(seed)) % 6;
    aluOp       = isaPkg::aluOp_e'(pick[2:0]);
    pick        = $unsigned($random(seed)) % 4;
    branchCond  = isaPkg::branchCond_e'(pick[1:0]);
    biasNotTaken = ($unsigned($random(seed)) % 8) != 0;
    if (issueKind == isaPkg::OP_ALU && ($unsigned($random(seed)) % 8) == 0) b = a; // SLT tie
    if (issueKind == isaPkg::OP_BRANCH && biasNotTaken && expectTaken(branchCond, a, b)) begin
      case (branchCond)
        isaPkg::BEQ: b = ~a;
        isaPkg::BNE: b = a;
        default: begin
          if (a == b) begin
            a = {1'b1, {(WIDTH-1){1'b0}}}; // Most negative value
            b = '0;
          end else begin
            swap = a; // Reversed order flips BLT and BGE
            a    = b;
            b    = swap;
          end
        end
      endcase
    end
    operandA = a;
    operandB = b;
  endtask

  // Checks the outputs ahead of the next rising edge and steps the model through it
  task automatic checkEdge();
    expectEntry_t        head;
    expectEntry_t        entry;
    logic                expectFlush;
    logic                accepted;
    logic [TAG_BITS-1:0] wantTag;
    int                  latency;
    int                  bound;
    expectFlush = 1'b0;
    cycleCount++;
    assert (!(pending.size() == DEPTH && issueReady)) else
      reportMismatch("issueReady high with the reorder buffer full");
    if (commitValid) begin
      assert (pending.size() != 0) else
        reportMismatch($sformatf("commit of tag %0d with nothing outstanding", commitTag));
      if (haveLastCommit) begin
        wantTag = lastCommitTag + 1'b1;
        assert (commitTag === wantTag) else
          reportMismatch($sformatf("commit tag %0d, expected %0d", commitTag, wantTag));
      end
      lastCommitTag  = commitTag;
      haveLastCommit = 1'b1;
      if (pending.size() != 0) begin
        head = pending.pop_front();
        commitCount++;
        assert (commitTag === head.tag) else
          reportMismatch($sformatf("commit tag %0d, model has %0d", commitTag, head.tag));
        assert (commitIsBranch === head.isBranch) else
          reportMismatch($sformatf("tag %0d kind %b, expected %b", head.tag, commitIsBranch,
                                   head.isBranch));
        assert (commitResult === head.result) else
          reportMismatch($sformatf("tag %0d result %h, expected %h", head.tag, commitResult,
                                   head.result));
        assert (commitTaken === head.taken) else
          reportMismatch($sformatf("tag %0d taken %b, expected %b", head.tag, commitTaken,
                                   head.taken));
        if (head.isBranch) begin
          assert (commitTarget === head.target) else
            reportMismatch($sformatf("tag %0d target %h, expected %h", head.tag, commitTarget,
                                     head.target));
        end
        if (head.startedEmpty) begin
          latency = cycleCount - head.acceptCycle;
          bound   = head.isBranch ? BRANCH_BOUND : ALU_BOUND;
          assert (latency <= bound) else
            reportMismatch($sformatf("tag %0d took %0d cycles to commit, limit %0d", head.tag,
                                     latency, bound));
        end
        expectFlush = head.isBranch && head.taken;
      end
    end
    assert (flush === expectFlush) else
      reportMismatch($sformatf("flush %b, expected %b", flush, expectFlush));
    if (expectFlush) begin
      assert (!issueReady) else reportMismatch("issueReady high during a flush");
      pending.delete(); // Everything younger is squashed
      nextTag = head.tag + 1'b1;
      flushCount++;
    end
    accepted = issueValid && issueReady && !expectFlush;
    if (accepted) begin
      entry.tag          = nextTag;
      entry.isBranch     = (issueKind == isaPkg::OP_BRANCH);
      entry.taken        = entry.isBranch && expectTaken(branchCond, operandA, operandB);
      entry.result       = entry.isBranch ? {{(WIDTH-1){1'b0}}, entry.taken}
                                          : expectAlu(aluOp, operandA, operandB);
      entry.target       = issueTarget;
      entry.acceptCycle  = cycleCount;
      entry.startedEmpty = (pending.size() == 0);
      pending.push_back(entry);
      nextTag = nextTag + 1'b1;
      acceptCount++;
      holding = 1'b0;
    end
  endtask

  initial begin : stimulus
    seed           = 38028;
    errorCount     = 0;
    commitCount    = 0;
    flushCount     = 0;
    acceptCount    = 0;
    cycleCount     = 0;
    nextTag        = '0;
    lastCommitTag  = '0;
    haveLastCommit = 1'b0;
    holding        = 1'b0;
    issueValid     = 1'b0;
    issueKind      = isaPkg::OP_ALU;
    aluOp          = isaPkg::ADD;
    branchCond     = isaPkg::BEQ;
    operandA       = '0;
    operandB       = '0;
    issueTarget    = '0;
    @(negedge clk);
    while (rst === 1'b1) begin
      assert (commitValid === 1'b0 && flush === 1'b0) else
        reportMismatch("commitValid or flush high during reset");
      @(negedge clk);
    end
    while (!(acceptCount >= NUM_OPS && pending.size() == 0)) begin
      checkEdge();
      @(posedge clk);
      #1;
      if (acceptCount >= NUM_OPS) begin
        issueValid = 1'b0;
      end else if (!holding) begin
        drawOperation();
        holding = issueValid;
      end
      @(negedge clk);
    end
    // Idle tail where any late commit has no model entry
    repeat (2 * DEPTH) begin
      checkEdge();
      @(negedge clk);
    end
    $display("Summary: %0d errors, %0d accepted, %0d commits checked, %0d flushes",
             errorCount, acceptCount, commitCount, flushCount);
    if (errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Run timed out after %0d ns with %0d of %0d operations accepted",
             TIMEOUT_NS, acceptCount, NUM_OPS);
    $display("Checks failed");
    $finish;
  end

endmodule

//--- sim.f
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/aluUnit.sv
logic/latencyTimer.sv
logic/branchSequencer.sv
logic/branchUnit.sv
logic/cdbArbiter.sv
logic/reorderBuffer.sv
logic/writebackCore.sv
tb/tbClock.sv
tb/tbWritebackCore.sv

//--- run.sh
#!/bin/sh
# Builds and runs the writeback core testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tbWritebackCore -Mdir obj_dir -o simWritebackCore -f sim.f
./obj_dir/simWritebackCore | tee sim.log
if grep -q "Checks failed" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"
